/* sim.f */
+incdir+include
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decode.sv
design/reg_exec.sv
design/resp_build.sv
design/uart_cmd_top.sv
verif/tb_uart_cmd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the UART command testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
        --top-module tb_uart_cmd -o sim_tb_uart_cmd
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/sim_tb_uart_cmd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
        exit 1
fi
exit 0

/* verif/tb_uart_cmd.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart_cmd;

localparam int N_WRITES = 8;
localparam int N_BAD = 4;
localparam int N_CMDS = N_WRITES + `REG_COUNT + 2 * N_BAD;
localparam int TIMEOUT_CYCLES = N_CMDS * 3 * 10 * `UART_CLKS_PER_BIT + 2000;

logic clk;
logic rst_n;
logic rxd;
logic txd;

integer seed;
int value_errors;
int frame_errors;
int cycle_count;
logic [7:0] model [`REG_COUNT];

uart_cmd_top dut
(
        .clk   (clk),
        .rst_n (rst_n),
        .rxd   (rxd),
        .txd   (txd)
);

initial
begin
        clk = 1'b0;
        forever #20 clk = ~clk;
end

// hang guard, sized from the number of commands
initial
begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
                @(posedge clk);
                cycle_count++;
        end
        $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
end

//////////////////////////////////////////////////////////////////////
// serial host side
//////////////////////////////////////////////////////////////////////

task automatic drive_bit(input logic value);
        @(posedge clk);
        rxd <= value;
        repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
endtask

task automatic send_byte(input logic [7:0] data);
        drive_bit(1'b0);
        for (int i = 0; i < `UART_DATA_BITS; i++)
                drive_bit(data[i]);
        drive_bit(1'b1);
endtask

// waits for a start bit on txd and samples every bit at mid-period
task automatic receive_byte(output logic [7:0] data);
        while (txd !== 1'b0)
                @(posedge clk);
        repeat (`UART_CLKS_PER_BIT / 2) @(posedge clk);
        assert (txd === 1'b0)
        else
        begin
                $display("framing error at %0t: start bit was not low at mid-bit", $time);
                frame_errors++;
        end
        for (int i = 0; i < `UART_DATA_BITS; i++)
        begin
                repeat (`UART_CLKS_PER_BIT) @(posedge clk);
                data[i] = txd;
        end
        repeat (`UART_CLKS_PER_BIT) @(posedge clk);
        assert (txd === 1'b1)
        else
        begin
                $display("framing error at %0t: stop bit was not high at mid-bit", $time);
                frame_errors++;
        end
endtask

// the response can start before the last stop bit is fully sent
task automatic run_command(input logic [7:0] cmd_byte, input logic has_data,
                           input logic [7:0] data_byte, output logic [7:0] resp);
        fork
                begin
                        send_byte(cmd_byte);
                        if (has_data)
                                send_byte(data_byte);
                end
                receive_byte(resp);
        join
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] expected);
        assert (got === expected)
        else
        begin
                $display("[FAIL] %0t txd_byte got %02h expected %02h", $time, got, expected);
                value_errors++;
        end
endtask

//////////////////////////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////////////////////////

initial
begin
        logic [31:0] rnd;
        logic [3:0] addr;
        logic [7:0] data;
        logic [7:0] resp;
        logic [2:0] bad_bits;

        seed = 32'had2b0f09;
        value_errors = 0;
        frame_errors = 0;
        for (int i = 0; i < `REG_COUNT; i++)
                model[i] = 8'h00;
        rxd = 1'b1;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // quiet line after reset
        repeat (100)
        begin
                @(posedge clk);
                assert (txd === 1'b1)
                else
                begin
                        $display("txd left idle at %0t while rxd was idle", $time);
                        frame_errors++;
                end
        end

        for (int i = 0; i < N_WRITES; i++)
        begin
                rnd = $random(seed);
                addr = rnd[3:0];
                data = rnd[15:8];
                run_command({1'b1, 3'b000, addr}, 1'b1, data, resp);
                check_byte(resp, `RESP_ACK);
                model[addr] = data;
        end

        // 8 writes leave at least 8 addresses still zero
        for (int i = 0; i < `REG_COUNT; i++)
        begin
                addr = i[3:0];
                run_command({4'b0000, addr}, 1'b0, 8'h00, resp);
                check_byte(resp, model[addr]);
        end

        for (int i = 0; i < N_BAD; i++)
        begin
                rnd = $random(seed);
                addr = rnd[3:0];
                bad_bits = rnd[6:4];
                if (bad_bits == 3'b000)
                        bad_bits = 3'b001;
                run_command({rnd[7], bad_bits, addr}, 1'b0, 8'h00, resp);
                check_byte(resp, `RESP_NAK);
                run_command({4'b0000, addr}, 1'b0, 8'h00, resp);
                check_byte(resp, model[addr]);
        end

        repeat (20) @(posedge clk);
        $display("errors: value=%0d frame=%0d", value_errors, frame_errors);
        if (value_errors == 0 && frame_errors == 0)
                $display("TEST RESULT: PASS");
        else
                $display("TEST RESULT: FAIL");
        $finish;
end

endmodule

/* design/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top
(
        input  logic clk,
        input  logic rst_n,
        input  logic rxd,
        output logic txd
);

uart_pkg::uart_byte_t rx_byte;
logic rx_valid;
uart_pkg::cmd_t cmd;
logic cmd_valid;
uart_pkg::result_t res;
logic res_valid;
uart_pkg::uart_byte_t tx_byte;
logic tx_start;
logic tx_busy;

//////////////////////////////////////////////////////////////////////
// rx -> decode -> exec -> response -> tx
//////////////////////////////////////////////////////////////////////

uart_rx u_rx
(
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
);

cmd_decode u_dec
(
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
);

reg_exec u_exec
(
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .res       (res),
        .res_valid (res_valid)
);

resp_build u_resp
(
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .tx_busy   (tx_busy),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start)
);

uart_tx u_tx
(
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (txd),
        .tx_busy  (tx_busy)
);

endmodule

/* design/resp_build.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module resp_build
(
        input  logic                 clk,
        input  logic                 rst_n,
        input  uart_pkg::result_t    res,
        input  logic                 res_valid,
        input  logic                 tx_busy,
        output uart_pkg::uart_byte_t tx_byte,
        output logic                 tx_start
);

uart_pkg::uart_byte_t resp_byte;
logic pending;
logic tx_free;

// busy rises one cycle after the start strobe
assign tx_free = !tx_busy && !tx_start;

always_comb
begin
        case (res.op)
        uart_pkg::op_read:  resp_byte = res.rdata;
        uart_pkg::op_write: resp_byte = `RESP_ACK;
        default:            resp_byte = `RESP_NAK;
        endcase
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                pending  <= 1'b0;
                tx_start <= 1'b0;
        end
        else
        begin
                tx_start <= 1'b0;
                if (res_valid)
                begin
                        pending  <= !tx_free;
                        tx_start <= tx_free;
                end
                else if (pending && tx_free)
                begin
                        pending  <= 1'b0;
                        tx_start <= 1'b1;
                end
        end
end

// newer result overwrites a pending byte
always_ff @(posedge clk)
begin
        if (res_valid)
                tx_byte <= resp_byte;
end

endmodule

/* design/reg_exec.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module reg_exec
(
        input  logic              clk,
        input  logic              rst_n,
        input  uart_pkg::cmd_t    cmd,
        input  logic              cmd_valid,
        output uart_pkg::result_t res,
        output logic              res_valid
);

uart_pkg::uart_byte_t regs [`REG_COUNT];

//////////////////////////////////////////////////////////////////////
// register file, cleared on reset
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                res_valid <= 1'b0;
                for (int i = 0; i < `REG_COUNT; i++)
                        regs[i] <= '0;
        end
        else
        begin
                res_valid <= cmd_valid;
                if (cmd_valid && cmd.op == uart_pkg::op_write)
                        regs[cmd.addr] <= cmd.wdata;
        end
end

// rdata only matters for reads
always_ff @(posedge clk)
begin
        if (cmd_valid)
        begin
                res.op    <= cmd.op;
                res.rdata <= regs[cmd.addr];
        end
end

endmodule

/* design/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode
(
        input  logic                 clk,
        input  logic                 rst_n,
        input  uart_pkg::uart_byte_t rx_byte,
        input  logic                 rx_valid,
        output uart_pkg::cmd_t       cmd,
        output logic                 cmd_valid
);

typedef enum logic {dec_wait_cmd, dec_wait_data} dec_state_t;

dec_state_t state;
uart_pkg::cmd_op_t byte_op;

// bits 6..4 are reserved and must be zero
always_comb
begin
        if (rx_byte[6:4] != 3'b000)
                byte_op = uart_pkg::op_bad;
        else if (rx_byte[7])
                byte_op = uart_pkg::op_write;
        else
                byte_op = uart_pkg::op_read;
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                state     <= dec_wait_cmd;
                cmd_valid <= 1'b0;
        end
        else
        begin
                cmd_valid <= 1'b0;
                if (rx_valid)
                begin
                        if (state == dec_wait_data)
                        begin
                                state     <= dec_wait_cmd;
                                cmd_valid <= 1'b1;
                        end
                        else if (byte_op == uart_pkg::op_write)
                                state <= dec_wait_data;
                        else
                                cmd_valid <= 1'b1;
                end
        end
end

always_ff @(posedge clk)
begin
        if (rx_valid)
        begin
                if (state == dec_wait_cmd)
                begin
                        cmd.op   <= byte_op;
                        cmd.addr <= rx_byte[3:0];
                end
                else
                        cmd.wdata <= rx_byte;
        end
end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx
(
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 tx_start,
        input  uart_pkg::uart_byte_t tx_byte,
        output logic                 txd,
        output logic                 tx_busy
);

localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
localparam int IDX_W = $clog2(`UART_DATA_BITS);

typedef enum logic [2:0]
{
        tx_idle,
        tx_start_bit,
        tx_data_bits,
        tx_stop_bit,
        tx_cleanup
} tx_state_t;

tx_state_t state;
logic [CNT_W-1:0] cnt;
logic [IDX_W-1:0] bit_idx;
logic bit_end;
uart_pkg::uart_byte_t data_q;

assign bit_end = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
assign tx_busy = (state != tx_idle);

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                state   <= tx_idle;
                cnt     <= '0;
                bit_idx <= '0;
                txd     <= 1'b1;
        end
        else
        begin
                cnt <= bit_end ? '0 : cnt + 1'b1;
                case (state)
                tx_idle:
                begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        if (tx_start)
                        begin
                                state <= tx_start_bit;
                                txd   <= 1'b0;
                        end
                end
                tx_start_bit:
                        if (bit_end)
                        begin
                                state <= tx_data_bits;
                                txd   <= data_q[0];
                        end
                tx_data_bits:
                        if (bit_end)
                        begin
                                bit_idx <= bit_idx + 1'b1;
                                if (bit_idx == IDX_W'(`UART_DATA_BITS - 1))
                                begin
                                        state <= tx_stop_bit;
                                        txd   <= 1'b1;
                                end
                                else
                                        txd <= data_q[1];
                        end
                tx_stop_bit:
                        if (bit_end)
                                state <= tx_cleanup;
                // one extra cycle before idle
                default:
                        state <= tx_idle;
                endcase
        end
end

always_ff @(posedge clk)
begin
        if (state == tx_idle && tx_start)
                data_q <= tx_byte;
        else if (state == tx_data_bits && bit_end)
                data_q <= data_q >> 1;
end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx
(
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 rxd,
        output uart_pkg::uart_byte_t rx_byte,
        output logic                 rx_valid
);

localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
localparam int IDX_W = $clog2(`UART_DATA_BITS);

typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

rx_state_t state;
logic [CNT_W-1:0] cnt;
logic [IDX_W-1:0] bit_idx;
logic rxd_meta;
logic rxd_sync;
logic rxd_prev;
logic bit_end;
logic half_bit;

assign bit_end  = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
assign half_bit = (cnt == CNT_W'(`UART_CLKS_PER_BIT / 2 - 1));

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                rxd_meta <= 1'b1;
                rxd_sync <= 1'b1;
                rxd_prev <= 1'b1;
                state    <= rx_idle;
                cnt      <= '0;
                bit_idx  <= '0;
                rx_valid <= 1'b0;
        end
        else
        begin
                rxd_meta <= rxd;
                rxd_sync <= rxd_meta;
                rxd_prev <= rxd_sync;
                rx_valid <= 1'b0;
                case (state)
                rx_idle:
                begin
                        cnt <= '0;
                        // falling edge marks the start bit
                        if (rxd_prev && !rxd_sync)
                                state <= rx_start;
                end
                rx_start:
                begin
                        cnt <= cnt + 1'b1;
                        if (half_bit)
                        begin
                                cnt     <= '0;
                                bit_idx <= '0;
                                // a high line here was only a glitch
                                state   <= rxd_sync ? rx_idle : rx_data;
                        end
                end
                rx_data:
                begin
                        cnt <= cnt + 1'b1;
                        if (bit_end)
                        begin
                                cnt     <= '0;
                                bit_idx <= bit_idx + 1'b1;
                                if (bit_idx == IDX_W'(`UART_DATA_BITS - 1))
                                        state <= rx_stop;
                        end
                end
                default:
                begin
                        cnt <= cnt + 1'b1;
                        if (bit_end)
                        begin
                                state    <= rx_idle;
                                // framing error drops the byte
                                rx_valid <= rxd_sync;
                        end
                end
                endcase
        end
end

// lsb arrives first, shift in from the top
always_ff @(posedge clk)
begin
        if (state == rx_data && bit_end)
                rx_byte <= {rxd_sync, rx_byte[`UART_DATA_BITS-1:1]};
end

endmodule

/* design/uart_pkg.sv */
package uart_pkg;

        // one byte on the serial line
        typedef logic [7:0] uart_byte_t;

        // register file index
        typedef logic [3:0] reg_addr_t;

        // decoded command class
        typedef enum logic [1:0]
        {
                op_read  = 2'd0,
                op_write = 2'd1,
                op_bad   = 2'd2
        } cmd_op_t;

        // decoded command, 14 bits
        typedef struct packed
        {
                cmd_op_t    op;
                reg_addr_t  addr;
                uart_byte_t wdata;
        } cmd_t;

        // outcome of one command
        typedef struct packed
        {
                cmd_op_t    op;
                uart_byte_t rdata;
        } result_t;

endpackage

/* include/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// serial line framing
//////////////////////////////////////////////////////////////////////

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// data bits per frame, sent lsb first
`define UART_DATA_BITS 8

//////////////////////////////////////////////////////////////////////
// register file and responses
//////////////////////////////////////////////////////////////////////

`define REG_COUNT 16

// ascii ack and nak
`define RESP_ACK 8'h06
`define RESP_NAK 8'h15

`endif
